//--- dma_backend.sv
/*
 * Backend issue stage
 * Forwards pieces to the bus under an outstanding limit
 * and turns done pulses into completion metadata
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_backend (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dma_split_pkg::burst_req_t burst_req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output dma_split_pkg::meta_t      meta_o,
  output dma_split_pkg::burst_req_t bus_req_o,
  output logic                      bus_valid_o,
  input  logic                      bus_ready_i,
  input  logic                      bus_done_i
);

  localparam int unsigned CNT_W = $clog2(`DMA_MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] outstanding_d;
  logic             can_issue;
  logic             issue;

  // Hold off the bus once the limit is reached
  assign can_issue = (outstanding_q != CNT_W'(`DMA_MAX_OUTSTANDING));

  assign bus_req_o   = burst_req_i;
  assign bus_valid_o = valid_i && can_issue;
  assign ready_o     = bus_ready_i && can_issue;
  assign issue       = bus_valid_o && bus_ready_i;

  always_comb begin
    outstanding_d = outstanding_q;
    if (issue && !bus_done_i) begin
      outstanding_d = outstanding_q + 1'b1;
    end else if (!issue && bus_done_i) begin
      outstanding_d = outstanding_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_d;
    end
  end

  // One completion per done pulse
  assign meta_o.trans_complete = bus_done_i;
  assign meta_o.backend_idle   = (outstanding_q == '0);

endmodule

`default_nettype wire

//--- dma_job_queue.sv
/*
 * Job queue for incoming burst requests
 * Circular buffer with registered ready and head entry
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_job_queue (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  dma_split_pkg::burst_req_t in_req_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output dma_split_pkg::burst_req_t out_req_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  import dma_split_pkg::*;

  localparam int unsigned DEPTH = `DMA_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  burst_req_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             ready_q;
  logic             push;
  logic             pop;

  assign push = in_valid_i && ready_q;
  assign pop  = out_valid_o && out_ready_i;

  assign in_ready_o  = ready_q;
  assign out_valid_o = (count_q != '0);
  assign out_req_o   = mem[rd_ptr_q];

  // Simultaneous push and pop leave the fill level alone
  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // Accept again as soon as a slot frees up
      ready_q <= (count_d != CNT_W'(DEPTH));
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_req_i;
    end
  end

endmodule

`default_nettype wire

//--- dma_split.f
+incdir+.
dma_split_pkg.sv
dma_job_queue.sv
dma_split_midend.sv
dma_backend.sv
dma_split_top.sv
dma_split_assert.sv
dma_split_checker.sv
dma_split_tb.sv

//--- dma_split_assert.sv
/*
 * Bound assertions on the DMA split top level
 * Bus handshake stability, outstanding limit, midend reset state
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_split_assert (
  input logic                        clk_i,
  input logic                        rst_i,
  input dma_split_pkg::burst_req_t   bus_req_i,
  input logic                        bus_valid_i,
  input logic                        bus_ready_i,
  input logic                        bus_done_i,
  input dma_split_pkg::split_state_e split_state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import dma_split_pkg::*;

  int bus_outstanding;

  // Pieces accepted by the bus and not yet done, counted at the ports
  always @(posedge clk_i) begin
    if (rst_i) begin
      bus_outstanding <= 0;
    end else begin
      bus_outstanding <= bus_outstanding + ((bus_valid_i && bus_ready_i) ? 1 : 0)
                         - (bus_done_i ? 1 : 0);
    end
  end

  // A stalled piece keeps valid and payload
  assert property (@(posedge clk_i) disable iff (rst_i)
    (bus_valid_i && !bus_ready_i) |=> (bus_valid_i && $stable(bus_req_i)))
    else $error("bus request changed or dropped before its handshake");

  assert property (@(posedge clk_i) disable iff (rst_i)
    (bus_outstanding == `DMA_MAX_OUTSTANDING) |-> !bus_valid_i)
    else $error("bus valid raised with the outstanding limit reached");

  assert property (@(posedge clk_i) rst_i |=> (split_state_i == SPLIT_IDLE))
    else $error("midend not idle after reset");

endmodule

`default_nettype wire

//--- dma_split_checker.sv
/*
 * Checker for the DMA split testbench
 * Reference split function, expected piece queue, completion model
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_split_checker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dma_split_pkg::burst_req_t req_i,
  input  logic                      req_valid_i,
  input  logic                      req_ready_i,
  input  dma_split_pkg::burst_req_t bus_req_i,
  input  logic                      bus_valid_i,
  input  logic                      bus_ready_i,
  input  logic                      bus_done_i,
  input  logic                      done_i,
  input  logic                      idle_i,
  output int                        err_count_o,
  output int                        piece_count_o,
  output int                        pending_o,
  output int                        stall_count_o,
  output int                        done_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import dma_split_pkg::*;

  localparam int MAX_PIECES = 8;

  typedef burst_req_t piece_list_t [MAX_PIECES];

  burst_req_t exp_q[$];
  int         inflight;

  // Walk the request one region at a time from the boundary address
  function automatic int split_ref(input burst_req_t req, output piece_list_t pieces);
    logic [`DMA_ADDR_WIDTH-1:0] bound;
    logic [`DMA_ADDR_WIDTH-1:0] src;
    logic [`DMA_ADDR_WIDTH-1:0] dst;
    int                         left;
    int                         room;
    int                         step;
    int                         n;
    n = 0;
    src = req.src;
    dst = req.dst;
    bound = ((longint'(req.src) >= longint'(`DMA_REGION_START)) &&
             (longint'(req.src) < longint'(`DMA_REGION_END))) ? src : dst;
    left = int'(req.num_bytes);
    while (left > 0 && n < MAX_PIECES) begin
      room = `DMA_REGION_WIDTH - int'(bound % `DMA_ADDR_WIDTH'(`DMA_REGION_WIDTH));
      step = (left < room) ? left : room;
      pieces[n] = '{src: src, dst: dst, num_bytes: `DMA_LEN_WIDTH'(step)};
      src = src + `DMA_ADDR_WIDTH'(step);
      dst = dst + `DMA_ADDR_WIDTH'(step);
      bound = bound + `DMA_ADDR_WIDTH'(step);
      left = left - step;
      n++;
    end
    return n;
  endfunction

  always @(posedge clk_i) begin : compare
    piece_list_t pieces;
    burst_req_t  exp_piece;
    int          n;
    int          i;
    int          next_inflight;
    logic        issue;
    if (rst_i) begin
      exp_q.delete();
      inflight = 0;
      pending_o = 0;
    end else begin
      issue = bus_valid_i && bus_ready_i;
      if (issue) begin
        if (exp_q.size() == 0) begin
          $display("ERR %0t: unexpected piece src %h dst %h len %0d", $time,
                   bus_req_i.src, bus_req_i.dst, bus_req_i.num_bytes);
          err_count_o++;
        end else begin
          exp_piece = exp_q.pop_front();
          if (bus_req_i !== exp_piece) begin
            $display("ERR %0t: piece %h/%h/%0d, expected %h/%h/%0d", $time,
                     bus_req_i.src, bus_req_i.dst, bus_req_i.num_bytes,
                     exp_piece.src, exp_piece.dst, exp_piece.num_bytes);
            err_count_o++;
          end
        end
        piece_count_o++;
      end
      if (req_valid_i && req_ready_i) begin
        n = split_ref(req_i, pieces);
        for (i = 0; i < n; i++) begin
          exp_q.push_back(pieces[i]);
        end
      end
      if (req_valid_i && !req_ready_i) begin
        stall_count_o++;
      end
      // Pieces on the bus minus done pulses
      next_inflight = inflight + (issue ? 1 : 0) - (bus_done_i ? 1 : 0);
      if (done_i !== (inflight == 1 && next_inflight == 0)) begin
        $display("ERR %0t: done_o is %b with %0d pieces in flight", $time, done_i, inflight);
        err_count_o++;
      end
      if (idle_i !== (inflight == 0)) begin
        $display("ERR %0t: idle_o is %b with %0d pieces in flight", $time, idle_i, inflight);
        err_count_o++;
      end
      if (done_i) begin
        done_count_o++;
      end
      inflight = next_inflight;
      pending_o = exp_q.size();
    end
  end

endmodule

`default_nettype wire

//--- dma_split_consts.svh
/*
 * Geometry and sizing constants for the DMA split subsystem
 * Address and length widths, region window, queue and issue limits
 */

`ifndef DMA_SPLIT_CONSTS_SVH
`define DMA_SPLIT_CONSTS_SVH

// Address and byte-count widths
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 16

// Region size in bytes, must be a power of two
`define DMA_REGION_WIDTH 64

// Window where the source address sets the split points
`define DMA_REGION_START 32'h0000_0000
`define DMA_REGION_END 32'h1000_0000

// Job queue entries
`define DMA_QUEUE_DEPTH 4

// Pieces issued to the bus but not yet done
`define DMA_MAX_OUTSTANDING 4

`endif

//--- dma_split_midend.sv
/*
 * Split midend
 * Cuts burst requests at region boundaries and tracks pieces in flight
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_split_midend (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dma_split_pkg::burst_req_t burst_req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output dma_split_pkg::meta_t      meta_o,
  output dma_split_pkg::burst_req_t burst_req_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  input  dma_split_pkg::meta_t      meta_i
);

  import dma_split_pkg::*;

  localparam int unsigned REGION_BITS = $clog2(`DMA_REGION_WIDTH);
  localparam int unsigned CNT_W       = $clog2(`DMA_MAX_OUTSTANDING + 1);

  localparam logic [`DMA_LEN_WIDTH-1:0] REGION_LEN = `DMA_LEN_WIDTH'(`DMA_REGION_WIDTH);

  logic [`DMA_ADDR_WIDTH-1:0] start_addr;
  logic [`DMA_LEN_WIDTH-1:0]  dist_len;
  logic [`DMA_LEN_WIDTH-1:0]  first_len;
  logic                       fits;
  logic                       handed;

  split_state_e state_d, state_q;
  burst_req_t   req_d, req_q;

  logic [CNT_W-1:0] num_trans_d, num_trans_q;

  // Boundary address follows src inside the window, dst elsewhere
  always_comb begin
    if ((burst_req_i.src - `DMA_REGION_START) < (`DMA_REGION_END - `DMA_REGION_START)) begin
      start_addr = burst_req_i.src;
    end else begin
      start_addr = burst_req_i.dst;
    end
  end

  // Bytes left up to the next region multiple
  assign dist_len  = REGION_LEN - `DMA_LEN_WIDTH'(start_addr[REGION_BITS-1:0]);
  assign fits      = (burst_req_i.num_bytes <= dist_len);
  assign first_len = fits ? burst_req_i.num_bytes : dist_len;

  always_comb begin
    state_d     = state_q;
    req_d       = req_q;
    burst_req_o = burst_req_i;
    valid_o     = 1'b0;
    ready_o     = 1'b0;
    handed      = 1'b0;

    case (state_q)
      SPLIT_IDLE: begin
        // First piece goes straight out, input retires with it
        burst_req_o.num_bytes = first_len;
        valid_o = valid_i;
        ready_o = ready_i;
        if (valid_i && ready_i) begin
          handed = 1'b1;
          if (!fits) begin
            req_d.src       = burst_req_i.src + `DMA_ADDR_WIDTH'(first_len);
            req_d.dst       = burst_req_i.dst + `DMA_ADDR_WIDTH'(first_len);
            req_d.num_bytes = burst_req_i.num_bytes - first_len;
            state_d         = SPLIT_BUSY;
          end
        end
      end
      SPLIT_BUSY: begin
        // Remainder is region aligned now
        burst_req_o = req_q;
        if (req_q.num_bytes > REGION_LEN) begin
          burst_req_o.num_bytes = REGION_LEN;
        end
        valid_o = 1'b1;
        if (ready_i) begin
          handed = 1'b1;
          if (req_q.num_bytes <= REGION_LEN) begin
            state_d = SPLIT_IDLE;
          end else begin
            req_d.src       = req_q.src + `DMA_ADDR_WIDTH'(`DMA_REGION_WIDTH);
            req_d.dst       = req_q.dst + `DMA_ADDR_WIDTH'(`DMA_REGION_WIDTH);
            req_d.num_bytes = req_q.num_bytes - REGION_LEN;
          end
        end
      end
      default: begin
        state_d = SPLIT_IDLE;
      end
    endcase
  end

  // Pieces handed to the backend and not yet done
  always_comb begin
    num_trans_d = num_trans_q;
    if (handed && !meta_i.trans_complete) begin
      num_trans_d = num_trans_q + 1'b1;
    end else if (!handed && meta_i.trans_complete) begin
      num_trans_d = num_trans_q - 1'b1;
    end
  end

  assign meta_o.backend_idle   = meta_i.backend_idle;
  assign meta_o.trans_complete = (num_trans_q == CNT_W'(1)) && (num_trans_d == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= SPLIT_IDLE;
      num_trans_q <= '0;
    end else begin
      state_q     <= state_d;
      num_trans_q <= num_trans_d;
    end
  end

  // Remainder payload
  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

endmodule

`default_nettype wire

//--- dma_split_pkg.sv
/*
 * Shared types of the DMA split subsystem
 * Burst request, completion metadata and midend state encoding
 */

`include "dma_split_consts.svh"

`default_nettype none

package dma_split_pkg;

  // One copy request or one piece of it
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] src;
    logic [`DMA_ADDR_WIDTH-1:0] dst;
    logic [`DMA_LEN_WIDTH-1:0]  num_bytes;
  } burst_req_t;

  // Completion info from backend to midend
  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } meta_t;

  // Midend splitting state
  typedef enum logic {
    SPLIT_IDLE = 1'b0,
    SPLIT_BUSY = 1'b1
  } split_state_e;

endpackage

`default_nettype wire

//--- dma_split_tb.sv
/*
 * Testbench top for the DMA split subsystem
 * Clock, reset, request stimulus, bus responder and watchdog
 */

`include "dma_split_consts.svh"

`default_nettype none

module dma_split_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dma_split_pkg::*;

  // Requests per test: 4, 4, 3, 24, 6 and 200
  localparam int NUM_REQS     = 241;
  localparam int MAX_PIECES   = 6;
  localparam int LIMIT_CYCLES = NUM_REQS * MAX_PIECES * 40;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  burst_req_t req = '0;
  logic       req_valid = 1'b0;
  logic       req_ready;
  burst_req_t bus_req;
  logic       bus_valid;
  logic       bus_ready = 1'b0;
  logic       bus_done = 1'b0;
  logic       done;
  logic       idle;

  int ready_pct = 100;
  int done_max = 0;
  int accepted = 0;
  int returned = 0;
  int done_wait = 0;
  int err_count;
  int piece_count;
  int pending;
  int stall_count;
  int done_count;
  int tb_errors = 0;
  int test_num = 0;
  int last_pieces = 0;
  int last_errs = 0;

  always #50 clk = ~clk;

  dma_split_top dut_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .bus_req_o   (bus_req),
    .bus_valid_o (bus_valid),
    .bus_ready_i (bus_ready),
    .bus_done_i  (bus_done),
    .done_o      (done),
    .idle_o      (idle)
  );

  dma_split_checker u_checker (
    .clk_i         (clk),
    .rst_i         (rst),
    .req_i         (req),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .bus_req_i     (bus_req),
    .bus_valid_i   (bus_valid),
    .bus_ready_i   (bus_ready),
    .bus_done_i    (bus_done),
    .done_i        (done),
    .idle_i        (idle),
    .err_count_o   (err_count),
    .piece_count_o (piece_count),
    .pending_o     (pending),
    .stall_count_o (stall_count),
    .done_count_o  (done_count)
  );

  bind dma_split_top dma_split_assert assert_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus_req_i     (bus_req_o),
    .bus_valid_i   (bus_valid_o),
    .bus_ready_i   (bus_ready_i),
    .bus_done_i    (bus_done_i),
    .split_state_i (u_midend.state_q)
  );

  // Pieces taken by the bus
  always @(posedge clk) begin
    if (!rst && bus_valid && bus_ready) begin
      accepted <= accepted + 1;
    end
  end

  // Random ready, done pulses in issue order
  always @(negedge clk) begin
    if (!rst) begin
      bus_ready <= (int'($urandom_range(99)) < ready_pct);
      bus_done <= 1'b0;
      if (accepted > returned) begin
        if (done_wait == 0) begin
          bus_done <= 1'b1;
          returned <= returned + 1;
          done_wait <= int'($urandom_range(done_max));
        end else begin
          done_wait <= done_wait - 1;
        end
      end
    end
  end

  function automatic burst_req_t make_req(input logic [`DMA_ADDR_WIDTH-1:0] src,
                                          input logic [`DMA_ADDR_WIDTH-1:0] dst,
                                          input int len);
    return '{src: src, dst: dst, num_bytes: `DMA_LEN_WIDTH'(len)};
  endfunction

  // Half the sources inside the window
  function automatic burst_req_t random_req();
    burst_req_t r;
    r.src = $urandom();
    if ($urandom_range(1) == 0) begin
      r.src = r.src & 32'h0FFF_FFFF;
    end
    r.dst = $urandom();
    r.num_bytes = `DMA_LEN_WIDTH'($urandom_range(300, 1));
    return r;
  endfunction

  task automatic send_req(input burst_req_t r);
    @(negedge clk);
    req = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (!(idle && pending == 0)) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    test_num++;
    $display("Test %0d %s: %0d pieces, %0d errors", test_num, name,
             piece_count - last_pieces, err_count + tb_errors - last_errs);
    last_pieces = piece_count;
    last_errs = err_count + tb_errors;
  endtask

  initial begin : stimulus
    int k;
    int stall_start;
    int done_start;
    void'($urandom(32'h2110_dd57));
    repeat (8) @(negedge clk);
    rst = 1'b0;

    done_max = 2;
    send_req(make_req(32'h0000_1000, 32'h0002_0000, 64));
    send_req(make_req(32'h0000_2010, 32'h0003_0007, 16));
    send_req(make_req(32'h0FFF_FFC0, 32'h8000_0000, 64));
    send_req(make_req(32'h0000_3000, 32'h0004_0001, 1));
    finish_test("unsplit");

    ready_pct = 80;
    done_max = 3;
    send_req(make_req(32'h0000_1030, 32'h0002_0005, 100));
    send_req(make_req(32'h0000_2001, 32'h0003_0000, 300));
    send_req(make_req(32'h0000_3040, 32'h0004_0020, 128));
    send_req(make_req(32'h0FFF_FFF0, 32'h0005_0000, 40));
    finish_test("source split");

    // Sources outside the window, split on dst
    send_req(make_req(32'h2000_0004, 32'h0006_0010, 200));
    send_req(make_req(32'hF000_0003, 32'h0007_0040, 64));
    send_req(make_req(32'h1000_0000, 32'h0008_003F, 2));
    finish_test("destination split");

    ready_pct = 25;
    done_max = 12;
    stall_start = stall_count;
    repeat (24) send_req(random_req());
    if (stall_count == stall_start) begin
      $display("Back-pressure never filled the job queue");
      tb_errors++;
    end
    finish_test("back-pressure");

    ready_pct = 60;
    done_max = 6;
    done_start = done_count;
    for (k = 0; k < 6; k++) begin
      send_req(make_req(32'h0000_5000 + 32'(k * 64), 32'h0009_0000, 8 + k));
      wait_drain();
    end
    if (done_count - done_start != 6) begin
      $display("ERR %0t: %0d done pulses for 6 drained requests", $time,
               done_count - done_start);
      tb_errors++;
    end
    finish_test("completion");

    ready_pct = 70;
    done_max = 4;
    repeat (200) send_req(random_req());
    finish_test("random mix");

    $display("Summary: %0d tests, %0d pieces, %0d errors", test_num, piece_count,
             err_count + tb_errors);
    if (err_count + tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_split_top.sv
/*
 * Top level of the DMA split subsystem
 * Job queue, split midend and backend issue stage
 */

`default_nettype none

module dma_split_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dma_split_pkg::burst_req_t req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output dma_split_pkg::burst_req_t bus_req_o,
  output logic                      bus_valid_o,
  input  logic                      bus_ready_i,
  input  logic                      bus_done_i,
  output logic                      done_o,
  output logic                      idle_o
);

  import dma_split_pkg::*;

  burst_req_t queue_req;
  logic       queue_valid;
  logic       queue_ready;
  burst_req_t piece_req;
  logic       piece_valid;
  logic       piece_ready;
  meta_t      backend_meta;
  meta_t      midend_meta;

  dma_job_queue u_queue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_req_i    (req_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .out_req_o   (queue_req),
    .out_valid_o (queue_valid),
    .out_ready_i (queue_ready)
  );

  dma_split_midend u_midend (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .burst_req_i (queue_req),
    .valid_i     (queue_valid),
    .ready_o     (queue_ready),
    .meta_o      (midend_meta),
    .burst_req_o (piece_req),
    .valid_o     (piece_valid),
    .ready_i     (piece_ready),
    .meta_i      (backend_meta)
  );

  dma_backend u_backend (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .burst_req_i (piece_req),
    .valid_i     (piece_valid),
    .ready_o     (piece_ready),
    .meta_o      (backend_meta),
    .bus_req_o   (bus_req_o),
    .bus_valid_o (bus_valid_o),
    .bus_ready_i (bus_ready_i),
    .bus_done_i  (bus_done_i)
  );

  // Summarized completion status
  assign done_o = midend_meta.trans_complete;
  assign idle_o = midend_meta.backend_idle;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA split testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module dma_split_tb \
  -f dma_split.f -o dma_split_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/dma_split_sim > sim.log 2>&1
grep -qx "Testbench passed" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
